// File: rtl/stq_pkg.sv
// shared word geometry, access size codes and entry states
// every access is one aligned lane of an 8-byte word
package stq_pkg;

  localparam int WORD_BYTES = 8;
  localparam int OFF_W      = 3;   // byte offset inside a word

  typedef logic [8*WORD_BYTES-1:0] word_t;
  typedef logic [WORD_BYTES-1:0]   byte_mask_t;

  typedef enum logic [1:0] {
    SZ_BYTE  = 2'd0,
    SZ_HALF  = 2'd1,
    SZ_WORD  = 2'd2,
    SZ_DWORD = 2'd3
  } size_e;

  typedef enum logic [1:0] {
    ENT_FREE  = 2'd0,
    ENT_ADDR  = 2'd1,  // address known, waiting for data
    ENT_READY = 2'd2
  } entry_state_e;

  // widen a byte enable into a bit mask over the whole word
  function automatic word_t byte_mask_bits(input byte_mask_t m);
    word_t bits;
    bits = '0;
    for (int b = 0; b < WORD_BYTES; b++) begin
      bits[8*b +: 8] = {8{m[b]}};
    end
    return bits;
  endfunction

endpackage

// File: rtl/stq_access_decode.sv
// splits a byte address into word address, offset and byte lanes
// offset is aligned down to the access size, so no access crosses a word
`timescale 1ns/10ps

module stq_access_decode #(
  parameter int ADDR_W = 16
) (
  input  logic [ADDR_W-1:0]                 addr,
  input  stq_pkg::size_e                    size,
  output logic [ADDR_W-stq_pkg::OFF_W-1:0]  word_addr,
  output logic [stq_pkg::OFF_W-1:0]         off,
  output stq_pkg::byte_mask_t               bytes
);
  import stq_pkg::*;

  logic [OFF_W-1:0] raw_off;

  assign word_addr = addr[ADDR_W-1:OFF_W];
  assign raw_off   = addr[OFF_W-1:0];

  always_comb begin
    off   = '0;
    bytes = '0;
    case (size)
      SZ_BYTE: begin
        off   = raw_off;
        bytes = byte_mask_t'(1'b1) << off;
      end
      SZ_HALF: begin
        off   = {raw_off[2:1], 1'b0};
        bytes = byte_mask_t'(2'b11) << off;
      end
      SZ_WORD: begin
        off   = {raw_off[2], 2'b00};
        bytes = byte_mask_t'(4'hf) << off;
      end
      SZ_DWORD: begin
        off   = '0;  // whole word
        bytes = '1;
      end
    endcase
  end

endmodule

// File: rtl/stq_age_select.sv
// finds the youngest set bit of an overlap vector, counting age from head
// DEPTH must be a power of two so index arithmetic wraps by itself
`timescale 1ns/10ps

module stq_age_select #(
  parameter  int DEPTH = 16,
  localparam int IDX_W = $clog2(DEPTH)
) (
  input  logic [DEPTH-1:0] ovl,
  input  logic [IDX_W-1:0] head,
  output logic [IDX_W-1:0] sel_idx,
  output logic             ovl_any
);

  logic [2*DEPTH-1:0] dbl;
  logic [DEPTH-1:0]   rot;
  logic [IDX_W-1:0]   pos;

  // bit 0 of rot is the oldest entry
  assign dbl = {ovl, ovl} >> head;
  assign rot = dbl[DEPTH-1:0];

  always_comb begin
    pos = '0;
    for (int i = 0; i < DEPTH; i++) begin
      if (rot[i]) begin
        pos = IDX_W'(i);  // last hit wins, youngest
      end
    end
  end

  assign sel_idx = head + pos;  // rotate back
  assign ovl_any = |ovl;

endmodule

// File: rtl/stq_entry_array.sv
// store queue entries with head/tail pointers and in-order retire
// checks see the entry state from before the current edge
// a full queue drops allocations, retire of a head without data is ignored
`timescale 1ns/10ps

module stq_entry_array #(
  parameter  int DEPTH  = 16,
  parameter  int ADDR_W = 16,
  localparam int IDX_W  = $clog2(DEPTH),
  localparam int WA_W   = ADDR_W - stq_pkg::OFF_W
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       wrt_en,
  input  logic [WA_W-1:0]            wrt_word,
  input  logic [stq_pkg::OFF_W-1:0]  wrt_off,
  input  stq_pkg::byte_mask_t        wrt_bytes,
  input  logic                       upd_en,
  input  logic [IDX_W-1:0]           upd_idx,
  input  stq_pkg::word_t             upd_data,
  input  logic [WA_W-1:0]            chk_word,
  input  stq_pkg::byte_mask_t        chk_bytes,
  input  logic                       ret_en,
  output logic                       full,
  output logic                       ovl_any,
  output stq_pkg::byte_mask_t        sel_bytes,
  output logic                       sel_ready,
  output stq_pkg::word_t             sel_data,
  output logic                       ret_valid,
  output logic [ADDR_W-1:0]          ret_addr,
  output stq_pkg::byte_mask_t        ret_bytes,
  output stq_pkg::word_t             ret_data
);
  import stq_pkg::*;

  entry_state_e     ent_state [DEPTH];
  logic [WA_W-1:0]  ent_word  [DEPTH];
  logic [OFF_W-1:0] ent_off   [DEPTH];
  byte_mask_t       ent_bytes [DEPTH];
  word_t            ent_data  [DEPTH];  // value already placed in its byte lanes

  logic [IDX_W-1:0] head;
  logic [IDX_W-1:0] tail;
  logic [IDX_W:0]   count;

  logic             do_alloc;
  logic             do_upd;
  logic             do_ret;
  logic [DEPTH-1:0] ovl;
  logic [IDX_W-1:0] sel_idx;

  assign full     = (count == (IDX_W+1)'(DEPTH));
  assign do_alloc = wrt_en && !full;
  assign do_upd   = upd_en && (ent_state[upd_idx] != ENT_FREE);
  assign do_ret   = ret_en && (ent_state[head] == ENT_READY);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        ent_state[i] <= ENT_FREE;
      end
      head      <= '0;
      tail      <= '0;
      count     <= '0;
      ret_valid <= 1'b0;
      ret_addr  <= '0;
      ret_bytes <= '0;
      ret_data  <= '0;
    end else begin
      ret_valid <= 1'b0;
      if (do_alloc) begin
        ent_state[tail] <= ENT_ADDR;
        tail            <= tail + 1'b1;
      end
      if (do_upd) begin
        ent_state[upd_idx] <= ENT_READY;
      end
      // retire last so a same-edge update cannot revive the head
      if (do_ret) begin
        ent_state[head] <= ENT_FREE;
        head            <= head + 1'b1;
        ret_valid       <= 1'b1;
        ret_addr        <= {ent_word[head], ent_off[head]};
        ret_bytes       <= ent_bytes[head];
        ret_data        <= ent_data[head];
      end
      case ({do_alloc, do_ret})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_alloc) begin
      ent_word[tail]  <= wrt_word;
      ent_off[tail]   <= wrt_off;
      ent_bytes[tail] <= wrt_bytes;
    end
    if (do_upd) begin
      ent_data[upd_idx] <= (upd_data << {ent_off[upd_idx], 3'b000})
                           & byte_mask_bits(ent_bytes[upd_idx]);
    end
  end

  // same word and at least one shared byte lane
  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      ovl[i] = (ent_state[i] != ENT_FREE) && (ent_word[i] == chk_word)
               && |(ent_bytes[i] & chk_bytes);
    end
  end

  stq_age_select #(
    .DEPTH (DEPTH)
  ) u_age (
    .ovl     (ovl),
    .head    (head),
    .sel_idx (sel_idx),
    .ovl_any (ovl_any)
  );

  assign sel_bytes = ent_bytes[sel_idx];
  assign sel_ready = (ent_state[sel_idx] == ENT_READY);
  assign sel_data  = ent_data[sel_idx];

endmodule

// File: rtl/stq_fwd_result.sv
// hit/stall/miss decision for one load check, registered as a pulse
// forwarded value is right aligned and zero extended to the load size
`timescale 1ns/10ps

module stq_fwd_result (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       chk_en,
  input  logic [stq_pkg::OFF_W-1:0]  chk_off,
  input  stq_pkg::byte_mask_t        chk_bytes,
  input  logic                       ovl_any,
  input  stq_pkg::byte_mask_t        sel_bytes,
  input  logic                       sel_ready,
  input  stq_pkg::word_t             sel_data,
  output logic                       fwd_done,
  output logic                       fwd_hit,
  output logic                       fwd_stall,
  output stq_pkg::word_t             fwd_data
);
  import stq_pkg::*;

  logic       covered;
  logic       hit;
  logic       stall;
  byte_mask_t load_mask;  // load lanes moved down to byte 0
  word_t      shifted;
  word_t      load_val;

  assign covered = ((chk_bytes & ~sel_bytes) == '0);
  assign hit     = ovl_any && covered && sel_ready;
  assign stall   = ovl_any && !hit;  // partial cover or no data yet

  assign load_mask = chk_bytes >> chk_off;
  assign shifted   = sel_data >> {chk_off, 3'b000};
  assign load_val  = shifted & byte_mask_bits(load_mask);

  always_ff @(posedge clk) begin
    if (rst) begin
      fwd_done  <= 1'b0;
      fwd_hit   <= 1'b0;
      fwd_stall <= 1'b0;
      fwd_data  <= '0;
    end else begin
      fwd_done  <= chk_en;
      fwd_hit   <= chk_en && hit;
      fwd_stall <= chk_en && stall;
      fwd_data  <= (chk_en && hit) ? load_val : '0;
    end
  end

endmodule

// File: rtl/stq_top.sv
// store queue with store-to-load forwarding, one port per function
// DEPTH must be a power of two; results arrive one cycle after the request
`timescale 1ns/10ps

module stq_top #(
  parameter  int DEPTH  = 16,
  parameter  int ADDR_W = 16,
  localparam int IDX_W  = $clog2(DEPTH)
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 wrt_en,
  input  logic [ADDR_W-1:0]    wrt_addr,
  input  stq_pkg::size_e       wrt_size,
  input  logic                 upd_en,
  input  logic [IDX_W-1:0]     upd_idx,
  input  stq_pkg::word_t       upd_data,
  input  logic                 chk_en,
  input  logic [ADDR_W-1:0]    chk_addr,
  input  stq_pkg::size_e       chk_size,
  input  logic                 ret_en,
  output logic                 full,
  output logic                 fwd_done,
  output logic                 fwd_hit,
  output logic                 fwd_stall,
  output stq_pkg::word_t       fwd_data,
  output logic                 ret_valid,
  output logic [ADDR_W-1:0]    ret_addr,
  output stq_pkg::byte_mask_t  ret_bytes,
  output stq_pkg::word_t       ret_data
);
  import stq_pkg::*;

  logic [ADDR_W-OFF_W-1:0] wrt_word;
  logic [OFF_W-1:0]        wrt_off;
  byte_mask_t              wrt_bytes;
  logic [ADDR_W-OFF_W-1:0] chk_word;
  logic [OFF_W-1:0]        chk_off;
  byte_mask_t              chk_bytes;

  logic                    ovl_any;
  byte_mask_t              sel_bytes;
  logic                    sel_ready;
  word_t                   sel_data;

  stq_access_decode #(.ADDR_W(ADDR_W)) u_dec_wrt (
    .addr      (wrt_addr),
    .size      (wrt_size),
    .word_addr (wrt_word),
    .off       (wrt_off),
    .bytes     (wrt_bytes)
  );

  stq_access_decode #(.ADDR_W(ADDR_W)) u_dec_chk (
    .addr      (chk_addr),
    .size      (chk_size),
    .word_addr (chk_word),
    .off       (chk_off),
    .bytes     (chk_bytes)
  );

  stq_entry_array #(
    .DEPTH  (DEPTH),
    .ADDR_W (ADDR_W)
  ) u_entries (
    .clk       (clk),
    .rst       (rst),
    .wrt_en    (wrt_en),
    .wrt_word  (wrt_word),
    .wrt_off   (wrt_off),
    .wrt_bytes (wrt_bytes),
    .upd_en    (upd_en),
    .upd_idx   (upd_idx),
    .upd_data  (upd_data),
    .chk_word  (chk_word),
    .chk_bytes (chk_bytes),
    .ret_en    (ret_en),
    .full      (full),
    .ovl_any   (ovl_any),
    .sel_bytes (sel_bytes),
    .sel_ready (sel_ready),
    .sel_data  (sel_data),
    .ret_valid (ret_valid),
    .ret_addr  (ret_addr),
    .ret_bytes (ret_bytes),
    .ret_data  (ret_data)
  );

  stq_fwd_result u_fwd (
    .clk       (clk),
    .rst       (rst),
    .chk_en    (chk_en),
    .chk_off   (chk_off),
    .chk_bytes (chk_bytes),
    .ovl_any   (ovl_any),
    .sel_bytes (sel_bytes),
    .sel_ready (sel_ready),
    .sel_data  (sel_data),
    .fwd_done  (fwd_done),
    .fwd_hit   (fwd_hit),
    .fwd_stall (fwd_stall),
    .fwd_data  (fwd_data)
  );

endmodule

// File: testbench/stq_tb_model.svh
// reference store queue for the testbench, one entry per allocated store
// expects DEPTH and the stq_pkg types to be visible where it is included
`ifndef STQ_TB_MODEL_SVH
`define STQ_TB_MODEL_SVH

logic [15:0] m_addr  [DEPTH];
size_e       m_size  [DEPTH];
logic        m_valid [DEPTH];
logic        m_has   [DEPTH];  // data arrived
word_t       m_lane  [DEPTH];
int          m_head;
int          m_tail;
int          m_count;

function automatic int size_bytes(input size_e s);
  case (s)
    SZ_BYTE: return 1;
    SZ_HALF: return 2;
    SZ_WORD: return 4;
    default: return 8;
  endcase
endfunction

// offset rounded down to a multiple of the size
function automatic int lane_off(input logic [15:0] a, input size_e s);
  int n;
  n = size_bytes(s);
  return (int'(a[2:0]) / n) * n;
endfunction

function automatic byte_mask_t lane_mask(input logic [15:0] a, input size_e s);
  byte_mask_t m;
  int off;
  int n;
  off = lane_off(a, s);
  n   = size_bytes(s);
  for (int b = 0; b < 8; b++) begin
    m[b] = (b >= off) && (b < off + n);
  end
  return m;
endfunction

function automatic word_t place_value(input word_t v, input logic [15:0] a, input size_e s);
  word_t w;
  byte_mask_t m;
  int off;
  w   = '0;
  m   = lane_mask(a, s);
  off = lane_off(a, s);
  for (int b = 0; b < 8; b++) begin
    if (m[b]) w[8*b +: 8] = v[8*(b-off) +: 8];
  end
  return w;
endfunction

// youngest overlapping store decides the result
task automatic expect_fwd(input logic [15:0] a, input size_e s,
                          output logic hit, output logic stall, output word_t data);
  int idx;
  byte_mask_t lm;
  byte_mask_t sm;
  int off;
  hit   = 1'b0;
  stall = 1'b0;
  data  = '0;
  lm    = lane_mask(a, s);
  off   = lane_off(a, s);
  for (int k = 1; k <= m_count; k++) begin
    idx = (m_tail - k + DEPTH) % DEPTH;
    sm  = lane_mask(m_addr[idx], m_size[idx]);
    if (m_addr[idx][15:3] == a[15:3] && (sm & lm) != 0) begin
      if ((lm & ~sm) == 0 && m_has[idx]) begin
        hit = 1'b1;
        for (int j = 0; j < size_bytes(s); j++) begin
          data[8*j +: 8] = m_lane[idx][8*(off+j) +: 8];
        end
      end else begin
        stall = 1'b1;
      end
      break;
    end
  end
endtask

`endif

// File: testbench/stq_tb.sv
// random store queue traffic from a fixed seed against a reference model
// the first DEPTH+4 cycles only fill the queue and every retire there is refused
`timescale 1ns/10ps

module stq_tb;
  import stq_pkg::*;

  localparam int DEPTH   = 16;
  localparam int ADDR_W  = 16;
  localparam int NUM_OPS = 600;

  `include "stq_tb_model.svh"

  logic clk, rst, wrt_en, upd_en, chk_en, ret_en;
  logic [15:0] wrt_addr, chk_addr;
  size_e wrt_size, chk_size;
  logic [3:0] upd_idx;
  word_t upd_data;
  logic full, fwd_done, fwd_hit, fwd_stall, ret_valid;
  word_t fwd_data, ret_data;
  logic [15:0] ret_addr;
  byte_mask_t ret_bytes;

  integer seed = 32'h0e129a49;
  logic [31:0] r;
  int mismatches = 0;
  int pulse_errs = 0;
  logic exp_chk = 0, exp_hit, exp_stall, exp_ret = 0;
  word_t exp_fdata, exp_rdata;
  logic [15:0] exp_raddr;
  byte_mask_t exp_rbytes;

  stq_top #(.DEPTH(DEPTH), .ADDR_W(ADDR_W)) u_stq_top (.*);

  always #10 clk = ~clk;

  initial begin  // watchdog
    #(2 * NUM_OPS * 20 + 4 * 20);
    $display("Test failures found");
    $display("run timed out before all operations finished");
    $finish;
  end

  function automatic logic [12:0] pick_word(input logic [2:0] sel);
    case (sel)
      3'd0, 3'd1: return 13'h0020;
      3'd2, 3'd3: return 13'h0021;
      3'd4, 3'd5: return 13'h0408;
      3'd6:       return 13'h0409;
      default:    return 13'h1fff;  // stores never land here
    endcase
  endfunction

  task automatic check_fwd(input logic hit, input logic stall, input word_t data);
    if (fwd_hit !== hit) begin
      $display("MISMATCH fwd_hit exp %h got %h", hit, fwd_hit);
      mismatches++;
    end
    if (fwd_stall !== stall) begin
      $display("MISMATCH fwd_stall exp %h got %h", stall, fwd_stall);
      mismatches++;
    end
    if (fwd_data !== data) begin
      $display("MISMATCH fwd_data exp %h got %h", data, fwd_data);
      mismatches++;
    end
  endtask

  task automatic check_ret(input logic [15:0] addr, input byte_mask_t bytes, input word_t data);
    if (ret_addr !== addr) begin
      $display("MISMATCH ret_addr exp %h got %h", addr, ret_addr);
      mismatches++;
    end
    if (ret_bytes !== bytes) begin
      $display("MISMATCH ret_bytes exp %h got %h", bytes, ret_bytes);
      mismatches++;
    end
    if (ret_data !== data) begin
      $display("MISMATCH ret_data exp %h got %h", data, ret_data);
      mismatches++;
    end
  endtask

  task automatic check_full(input logic exp_full);
    if (full !== exp_full) begin
      $display("MISMATCH full exp %h got %h", exp_full, full);
      mismatches++;
    end
  endtask

  task automatic check_outputs();
    if (fwd_done !== exp_chk) begin
      $display("fwd_done pulse %s at %0t", exp_chk ? "missing" : "unexpected", $time);
      pulse_errs++;
    end else if (exp_chk) begin
      check_fwd(exp_hit, exp_stall, exp_fdata);
    end
    if (ret_valid !== exp_ret) begin
      $display("ret_valid pulse %s at %0t", exp_ret ? "missing" : "unexpected", $time);
      pulse_errs++;
    end else if (exp_ret) begin
      check_ret(exp_raddr, exp_rbytes, exp_rdata);
    end
    check_full(m_count == DEPTH);
  endtask

  // expectations use the state from before the edge, then the model steps
  task automatic model_step();
    int h;
    exp_chk = chk_en;
    if (chk_en) expect_fwd(chk_addr, chk_size, exp_hit, exp_stall, exp_fdata);
    h = m_head;
    exp_ret = ret_en && m_count > 0 && m_has[h];
    if (exp_ret) begin
      exp_raddr  = {m_addr[h][15:3], 3'(lane_off(m_addr[h], m_size[h]))};
      exp_rbytes = lane_mask(m_addr[h], m_size[h]);
      exp_rdata  = m_lane[h];
    end
    if (upd_en && m_valid[upd_idx]) begin
      m_has[upd_idx]  = 1'b1;
      m_lane[upd_idx] = place_value(upd_data, m_addr[upd_idx], m_size[upd_idx]);
    end
    if (wrt_en && m_count < DEPTH) begin
      m_addr[m_tail]  = wrt_addr;
      m_size[m_tail]  = wrt_size;
      m_valid[m_tail] = 1'b1;
      m_has[m_tail]   = 1'b0;
      m_tail          = (m_tail + 1) % DEPTH;
      m_count++;
    end
    if (exp_ret) begin
      m_valid[h] = 1'b0;
      m_head     = (h + 1) % DEPTH;
      m_count--;
    end
  endtask

  initial begin
    clk      = 0;
    rst      = 1;
    wrt_en   = 0;
    upd_en   = 0;
    chk_en   = 0;
    ret_en   = 0;
    wrt_addr = '0;
    chk_addr = '0;
    wrt_size = SZ_BYTE;
    chk_size = SZ_BYTE;
    upd_idx  = '0;
    upd_data = '0;
    m_head   = 0;
    m_tail   = 0;
    m_count  = 0;
    for (int i = 0; i < DEPTH; i++) begin
      m_valid[i] = 1'b0;
      m_has[i]   = 1'b0;
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    for (int op = 0; op <= NUM_OPS; op++) begin
      @(posedge clk);
      r = $random(seed);
      if (op == NUM_OPS) begin  // drain the last results
        wrt_en <= 1'b0;
        upd_en <= 1'b0;
        chk_en <= 1'b0;
        ret_en <= 1'b0;
      end else begin
        wrt_en   <= (op < DEPTH + 4) ? 1'b1 : r[0];
        wrt_addr <= {pick_word({1'b0, r[2:1]}), r[5:3]};
        wrt_size <= size_e'(r[7:6]);
        upd_en   <= (op < DEPTH + 4) ? 1'b0 : (r[9:8] != 2'b00);
        upd_idx  <= r[13:10];
        upd_data <= {$random(seed), $random(seed)};
        chk_en   <= r[14] | r[15];
        chk_addr <= {pick_word(r[18:16]), r[21:19]};
        chk_size <= size_e'(r[23:22]);
        ret_en   <= (op < DEPTH + 4) ? 1'b1 : (r[25:24] == 2'b00) | r[26];
      end
      @(negedge clk);
      check_outputs();
      model_step();
    end
    @(posedge clk);
    @(negedge clk);
    check_outputs();
    $display("errors: %0d mismatches, %0d pulse errors", mismatches, pulse_errs);
    if (mismatches == 0 && pulse_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: stq.f
+incdir+testbench
rtl/stq_pkg.sv
rtl/stq_access_decode.sv
rtl/stq_age_select.sv
rtl/stq_entry_array.sv
rtl/stq_fwd_result.sv
rtl/stq_top.sv
testbench/stq_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := stq_tb
FILELIST  := stq.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Test failures found

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell grep -v '^+' $(FILELIST)) testbench/stq_tb_model.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "All tests passed!" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
